/* soc_timer_config.svh */
`ifndef SOC_TIMER_CONFIG_SVH
`define SOC_TIMER_CONFIG_SVH

// Timer bank size

`define NUM_TIMERS		4		// Timer instances on the CSR bus

// Bus and counter widths
`define DATA_WIDTH		32		// CSR data word and counter width
`define CSR_ADDR_WIDTH	14		// Word address, low 2 bits pick the register

// Register select field
`define REG_SEL_WIDTH	2		// Bits [1:0] of the word address

// Cycles the internal reset is held once hard_reset is gone
`define RESET_HOLD		64

// Status register bit that reflects and clears the pending flag
`define STATUS_PENDING_BIT	0

`endif

/* csr_pkg.sv */
`include "soc_timer_config.svh"

package csr_pkg;

	// One CSR bus request, one cycle wide
	typedef struct packed {
		logic							stb;	// Request strobe
		logic							we;		// 1 write, 0 read
		logic [`CSR_ADDR_WIDTH-1:0]		addr;	// Word address
		logic [`DATA_WIDTH-1:0]			data;	// Write data
	} csr_req_t;

	// Response back to the master
	typedef struct packed {
		logic							valid;	// One per accepted request
		logic [`DATA_WIDTH-1:0]			rdata;	// Zero for writes
	} csr_rsp_t;

	// Control register layout, enable sits in bit 0
	typedef struct packed {
		logic	irq_enable;		// Bit 2
		logic	autoreload;		// Bit 1
		logic	enable;			// Bit 0
	} timer_ctrl_t;

	// Register select, address bits [1:0]
	typedef enum logic [`REG_SEL_WIDTH-1:0] {
		REG_CTRL	= 2'd0,
		REG_COMPARE	= 2'd1,
		REG_COUNT	= 2'd2,
		REG_STATUS	= 2'd3
	} csr_reg_e;

endpackage

/* reset_stretch.sv */
`include "soc_timer_config.svh"

module reset_stretch (
	input  logic	sys_clk,
	input  logic	hard_reset,		// Async, active high
	output logic	sys_rst_o		// Stretched internal reset
);

	// Wide enough to hold the full hold length
	localparam int unsigned CNT_W = $clog2(`RESET_HOLD + 1);

	logic [CNT_W-1:0]	hold_cnt;

	// Loaded while hard_reset is up, then runs down once per cycle
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			hold_cnt <= CNT_W'(`RESET_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - CNT_W'(1);	// Stops at zero
		end
	end

	// High until the count reaches zero
	assign sys_rst_o = (hold_cnt != '0);

	// Release only after the last count step
	// A count of two or more must still hold reset on the next cycle
	a_hold_until_zero: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		(hold_cnt > CNT_W'(1)) |=> sys_rst_o
	) else $error("reset_stretch: sys_rst_o fell early");

	// Once released it stays released until the next hard reset
	a_no_rearm: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		!sys_rst_o |=> !sys_rst_o
	) else $error("reset_stretch: sys_rst_o rose without hard_reset");

endmodule

/* wb_csr_bridge.sv */
module wb_csr_bridge (
	input  logic				sys_clk,
	input  logic				hard_reset,
	input  logic				sys_rst_i,	// Requests dropped while high
	input  csr_pkg::csr_req_t	req_i,		// Master request with a one-cycle strobe
	output csr_pkg::csr_req_t	bus_o		// CSR bus to every timer
);
	import csr_pkg::*;

	logic		stb_q;		// Registered strobe
	csr_req_t	req_q;		// Registered payload

	// Strobe stage
	// No back-pressure, so a new request may land every cycle
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= req_i.stb & ~sys_rst_i;	// Discard during reset hold
		end
	end

	// Payload stage
	// Loaded only with a strobe and held otherwise
	always_ff @(posedge sys_clk) begin
		if (req_i.stb) begin
			req_q <= req_i;
		end
	end

	// Bus view
	// Captured payload with the strobe from the reset-aware stage
	always_comb begin
		bus_o		= req_q;
		bus_o.stb	= stb_q;
	end

	// Nothing reaches the bus while the system is held in reset
	// The strobe was registered a cycle earlier, so this also covers the release edge
	a_no_stb_in_reset: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		sys_rst_i |-> !bus_o.stb
	) else $error("wb_csr_bridge: bus strobe during reset hold");

endmodule

/* csr_timer.sv */
`include "soc_timer_config.svh"

module csr_timer #(
	parameter int unsigned INDEX = 0		// Timer number in address bits [13:2]
) (
	input  logic					sys_clk,
	input  logic					hard_reset,
	input  logic					sys_rst_i,
	input  csr_pkg::csr_req_t		bus_i,
	output logic [`DATA_WIDTH-1:0]	rdata_o,	// Zero unless this timer was read
	output logic					irq_o		// Level, pending and enabled
);
	import csr_pkg::*;

	localparam int unsigned IDX_W = `CSR_ADDR_WIDTH - `REG_SEL_WIDTH;

	// Timer state
	timer_ctrl_t				ctrl;
	logic [`DATA_WIDTH-1:0]		compare;
	logic [`DATA_WIDTH-1:0]		count;
	logic						pending;

	// Decode
	logic		hit;
	csr_reg_e	sel;
	logic		rd;
	logic		wr_ctrl;
	logic		wr_cmp;
	logic		wr_cnt;
	logic		wr_stat;
	logic		match;

	// Read path
	logic [`DATA_WIDTH-1:0]		rd_val;
	logic [`DATA_WIDTH-1:0]		rdata_q;
	logic						rd_hit_q;

	always_comb begin
		hit		= bus_i.stb &&
				  (bus_i.addr[`CSR_ADDR_WIDTH-1:`REG_SEL_WIDTH] == IDX_W'(INDEX));
		sel		= csr_reg_e'(bus_i.addr[`REG_SEL_WIDTH-1:0]);
		rd		= hit && !bus_i.we;
		wr_ctrl	= hit && bus_i.we && (sel == REG_CTRL);
		wr_cmp	= hit && bus_i.we && (sel == REG_COMPARE);
		wr_cnt	= hit && bus_i.we && (sel == REG_COUNT);
		wr_stat	= hit && bus_i.we && (sel == REG_STATUS);
		match	= ctrl.enable && (count == compare);	// Expiry this cycle
	end

	// Register mux, values before this edge's update
	always_comb begin
		rd_val = '0;
		case (sel)
			REG_CTRL:		rd_val[$bits(timer_ctrl_t)-1:0] = ctrl;
			REG_COMPARE:	rd_val = compare;
			REG_COUNT:		rd_val = count;
			REG_STATUS:		rd_val[`STATUS_PENDING_BIT] = pending;
			default:		rd_val = '0;
		endcase
	end

	// Count step first, bus writes after so they win on the same edge
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			ctrl	<= '0;
			compare	<= '0;
			count	<= '0;
			pending	<= 1'b0;
		end else if (sys_rst_i) begin
			ctrl	<= '0;
			compare	<= '0;
			count	<= '0;
			pending	<= 1'b0;
		end else begin
			if (ctrl.enable) begin
				if (match) begin
					count	<= '0;				// Wrap on compare
					pending	<= 1'b1;
					if (!ctrl.autoreload)
						ctrl.enable <= 1'b0;	// One-shot stops here
				end else begin
					count <= count + 1'b1;
				end
			end
			if (wr_ctrl)
				ctrl <= timer_ctrl_t'(bus_i.data[$bits(timer_ctrl_t)-1:0]);
			if (wr_cmp)
				compare <= bus_i.data;
			if (wr_cnt)
				count <= bus_i.data;
			if (wr_stat && bus_i.data[`STATUS_PENDING_BIT])
				pending <= 1'b0;				// Clear beats a set
		end
	end

	// Read capture, hit flag is control, data is payload
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset)
			rd_hit_q <= 1'b0;
		else if (sys_rst_i)
			rd_hit_q <= 1'b0;
		else
			rd_hit_q <= rd;
	end

	always_ff @(posedge sys_clk) begin
		if (rd)
			rdata_q <= rd_val;
	end

	assign rdata_o	= rd_hit_q ? rdata_q : '0;	// Other timers contribute zero
	assign irq_o	= pending & ctrl.irq_enable;

	// Stepping never carries count past a nonzero compare
	a_cnt_bound: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		(ctrl.enable && compare != '0 && count <= compare && !wr_cnt && !wr_cmp)
			|=> (count <= compare)
	) else $error("csr_timer %0d: count passed compare", INDEX);

	// Interrupt rides on pending, a status clear drops it next cycle
	a_irq_clear: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		(wr_stat && bus_i.data[`STATUS_PENDING_BIT]) |=> !irq_o
	) else $error("csr_timer %0d: irq survived a pending clear", INDEX);

endmodule

/* csr_collect.sv */
`include "soc_timer_config.svh"

module csr_collect (
	input  logic									sys_clk,
	input  logic									hard_reset,
	input  logic									sys_rst_i,
	input  csr_pkg::csr_req_t						bus_i,		// Same bus the timers see
	input  logic [`NUM_TIMERS-1:0][`DATA_WIDTH-1:0]	rdata_i,	// Per-timer read data
	input  logic [`NUM_TIMERS-1:0]					irq_i,		// Per-timer irq levels
	output csr_pkg::csr_rsp_t						rsp_o,
	output logic									irq_o
);

	// Stage matching the timers' read capture
	logic	stb_q;
	logic	we_q;

	// Response stage
	logic						valid_q;
	logic						irq_q;
	logic [`DATA_WIDTH-1:0]		rdata_or;
	logic [`DATA_WIDTH-1:0]		rdata_q;

	// Only the addressed timer drives non-zero data
	always_comb begin
		rdata_or = '0;
		for (int i = 0; i < `NUM_TIMERS; i++)
			rdata_or |= rdata_i[i];
	end

	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			stb_q	<= 1'b0;
			valid_q	<= 1'b0;
			irq_q	<= 1'b0;
		end else if (sys_rst_i) begin
			stb_q	<= 1'b0;
			valid_q	<= 1'b0;
			irq_q	<= 1'b0;
		end else begin
			stb_q	<= bus_i.stb;
			valid_q	<= stb_q;			// Reads and writes both answered
			irq_q	<= |irq_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		we_q	<= bus_i.we;
		rdata_q	<= we_q ? '0 : rdata_or;	// Writes return zero
	end

	assign rsp_o = '{valid: valid_q, rdata: rdata_q};
	assign irq_o = irq_q;

endmodule

/* timer_soc_top.sv */
`include "soc_timer_config.svh"

module timer_soc_top (
	input  logic				sys_clk,
	input  logic				hard_reset,		// Async, active high
	input  csr_pkg::csr_req_t	req_i,			// Master request, one-cycle strobe
	output csr_pkg::csr_rsp_t	rsp_o,			// Fixed three-cycle latency
	output logic				irq_o,			// OR of timer interrupts
	output logic				rst_busy_o		// Reset hold in progress
);
	import csr_pkg::*;

	logic										sys_rst;		// Stretched reset
	csr_req_t									csr_bus;		// Bridge to timers
	logic [`NUM_TIMERS-1:0][`DATA_WIDTH-1:0]	timer_rdata;
	logic [`NUM_TIMERS-1:0]						timer_irq;

	// Holds everything in reset for a while after hard_reset
	reset_stretch i_reset_stretch (
		.sys_clk	( sys_clk		),
		.hard_reset	( hard_reset	),
		.sys_rst_o	( sys_rst		)
	);

	// Master to CSR bus
	wb_csr_bridge i_bridge (
		.sys_clk	( sys_clk		),
		.hard_reset	( hard_reset	),
		.sys_rst_i	( sys_rst		),
		.req_i		( req_i			),
		.bus_o		( csr_bus		)
	);

	// Timer bank, each decodes its own index
	for (genvar gi = 0; gi < `NUM_TIMERS; gi++) begin : g_timer
		csr_timer #(
			.INDEX		( gi			)
		) i_timer (
			.sys_clk	( sys_clk			),
			.hard_reset	( hard_reset		),
			.sys_rst_i	( sys_rst			),
			.bus_i		( csr_bus			),
			.rdata_o	( timer_rdata[gi]	),
			.irq_o		( timer_irq[gi]		)
		);
	end

	// Read data and interrupt merge
	csr_collect i_collect (
		.sys_clk	( sys_clk		),
		.hard_reset	( hard_reset	),
		.sys_rst_i	( sys_rst		),
		.bus_i		( csr_bus		),
		.rdata_i	( timer_rdata	),
		.irq_i		( timer_irq		),
		.rsp_o		( rsp_o			),
		.irq_o		( irq_o			)
	);

	assign rst_busy_o = sys_rst;

endmodule

/* tb_checker.sv */
`include "soc_timer_config.svh"

module tb_checker (
	input  logic				sys_clk,
	input  logic				hard_reset,
	input  csr_pkg::csr_req_t	req_i,		// Master request as driven
	input  csr_pkg::csr_rsp_t	rsp_i,		// DUT response
	input  logic				irq_i,
	input  logic				rst_busy_i,
	output int					chk_cnt_o,
	output int					err_cnt_o
);
	import csr_pkg::*;

	localparam int DW = `DATA_WIDTH;

	// One expected response, due at a given edge
	typedef struct packed {
		int				due;
		logic [DW-1:0]	data;
	} exp_rsp_t;

	// Timer bank model
	timer_ctrl_t	m_ctrl [`NUM_TIMERS];
	logic [DW-1:0]	m_cmp [`NUM_TIMERS];
	logic [DW-1:0]	m_cnt [`NUM_TIMERS];
	logic			m_pend [`NUM_TIMERS];

	csr_req_t	bus_q;		// Accepted last edge, on the CSR bus now
	exp_rsp_t	exp_q [$];	// Oldest first
	int			cyc;		// Edge counter
	logic		irq_exp;	// irq_o due at this edge
	int			hold_cnt;	// Busy edges since hard_reset fell
	logic		hold_seen;

	initial begin
		chk_cnt_o	= 0;
		err_cnt_o	= 0;
		cyc			= 0;
		irq_exp		= 1'b0;
		hold_cnt	= 0;
		hold_seen	= 1'b0;
		bus_q		= '0;
	end

	task automatic flag_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		err_cnt_o++;
	endtask

	// All timer registers back to zero
	task automatic clear_model();
		for (int t = 0; t < `NUM_TIMERS; t++) begin
			m_ctrl[t]	= '0;
			m_cmp[t]	= '0;
			m_cnt[t]	= '0;
			m_pend[t]	= 1'b0;
		end
	endtask

	// Inputs sampled before the DUT registers move
	always @(posedge sys_clk) begin : model_step
		logic			exp_valid;
		logic			irq_now;
		int				idx;
		csr_reg_e		sel;
		logic [DW-1:0]	rval;
		exp_rsp_t		e;

		cyc++;
		if (hard_reset) begin
			clear_model();
			exp_q.delete();
			bus_q		= '0;
			irq_exp		= 1'b0;
			hold_cnt	= 0;
			hold_seen	= 1'b0;
		end else begin
			exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cyc);
			if (rsp_i.valid !== exp_valid)
				flag_error($sformatf("rsp valid %b, expected %b", rsp_i.valid, exp_valid));
			if (exp_valid) begin
				chk_cnt_o++;
				if (rsp_i.valid && rsp_i.rdata !== exp_q[0].data)
					flag_error($sformatf("rdata %h, expected %h",
						rsp_i.rdata, exp_q[0].data));
				void'(exp_q.pop_front());
			end

			chk_cnt_o++;	// Interrupt, one cycle behind the model
			if (irq_i !== irq_exp)
				flag_error($sformatf("irq_o %b, expected %b", irq_i, irq_exp));

			// Hold window length, measured once
			if (rst_busy_i) begin
				if (hold_seen)
					flag_error("rst_busy_o rose again without hard_reset");
				hold_cnt++;
			end else if (!hold_seen) begin
				hold_seen = 1'b1;
				chk_cnt_o++;
				if (hold_cnt != `RESET_HOLD)
					flag_error($sformatf("rst_busy_o high for %0d cycles, expected %0d",
						hold_cnt, `RESET_HOLD));
			end

			irq_now = 1'b0;
			for (int t = 0; t < `NUM_TIMERS; t++)
				irq_now |= m_pend[t] & m_ctrl[t].irq_enable;
			irq_exp = irq_now;

			if (rst_busy_i) begin
				clear_model();
				bus_q = '0;		// Requests in the hold window are dropped
			end else begin
				idx	= int'(bus_q.addr[`CSR_ADDR_WIDTH-1:`REG_SEL_WIDTH]);
				sel	= csr_reg_e'(bus_q.addr[`REG_SEL_WIDTH-1:0]);
				if (bus_q.stb) begin
					rval = '0;	// Writes and unmapped reads
					if (!bus_q.we && idx < `NUM_TIMERS) begin
						case (sel)
							REG_CTRL:		rval = DW'(m_ctrl[idx]);
							REG_COMPARE:	rval = m_cmp[idx];
							REG_COUNT:		rval = m_cnt[idx];
							default:		rval = DW'(m_pend[idx]);
						endcase
					end
					e.due	= cyc + 2;
					e.data	= rval;
					exp_q.push_back(e);
				end
				for (int t = 0; t < `NUM_TIMERS; t++) begin
					if (m_ctrl[t].enable) begin
						if (m_cnt[t] == m_cmp[t]) begin
							m_cnt[t]	= '0;
							m_pend[t]	= 1'b1;
							if (!m_ctrl[t].autoreload)
								m_ctrl[t].enable = 1'b0;	// One-shot
						end else begin
							m_cnt[t] = m_cnt[t] + DW'(1);
						end
					end
					// Bus write wins over the step
					if (bus_q.stb && bus_q.we && idx == t) begin
						case (sel)
							REG_CTRL:		m_ctrl[t] = timer_ctrl_t'(bus_q.data[2:0]);
							REG_COMPARE:	m_cmp[t] = bus_q.data;
							REG_COUNT:		m_cnt[t] = bus_q.data;
							default:		if (bus_q.data[0]) m_pend[t] = 1'b0;
						endcase
					end
				end
				bus_q = req_i;
			end
		end
	end

endmodule

/* tb_top.sv */
`include "soc_timer_config.svh"

module tb_top;
	import csr_pkg::*;

	localparam int			CLK_PERIOD		= 20;
	localparam int			DRIVE_DLY		= 2;	// After the rising edge
	localparam int			RESET_CYCLES	= 5;
	localparam int			READBACK_CYCLES	= 300;
	localparam int			COUNT_CYCLES	= 600;
	localparam int			IRQ_CYCLES		= 600;
	localparam int			BURST_CYCLES	= 400;
	localparam int			DRAIN_CYCLES	= 8;
	localparam int			TOTAL_CYCLES	= RESET_CYCLES + `RESET_HOLD + 2 + READBACK_CYCLES
		+ COUNT_CYCLES + IRQ_CYCLES + BURST_CYCLES + 5 * DRAIN_CYCLES;
	localparam int			MARGIN_CYCLES	= 100;
	localparam int			IDX_W			= `CSR_ADDR_WIDTH - `REG_SEL_WIDTH;
	localparam int			DW				= `DATA_WIDTH;
	localparam logic [31:0]	LFSR_SEED		= 32'hda06_3bd9;

	// Stimulus flavours
	localparam int MODE_READBACK	= 0;	// Timers stay stopped
	localparam int MODE_COUNT		= 1;	// Mostly enabled, no irq
	localparam int MODE_IRQ			= 2;	// Anything goes

	logic			sys_clk;
	logic			hard_reset;
	csr_req_t		req_i;
	csr_rsp_t		rsp_o;
	logic			irq_o;
	logic			rst_busy_o;
	int				chk_cnt;
	int				err_cnt;
	int				chk_mark;
	int				err_mark;
	logic [31:0]	lfsr;

	initial sys_clk = 1'b0;
	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	timer_soc_top i_dut (
		.sys_clk	( sys_clk		),
		.hard_reset	( hard_reset	),
		.req_i		( req_i			),
		.rsp_o		( rsp_o			),
		.irq_o		( irq_o			),
		.rst_busy_o	( rst_busy_o	)
	);

	tb_checker i_checker (
		.sys_clk	( sys_clk		),
		.hard_reset	( hard_reset	),
		.req_i		( req_i			),
		.rsp_i		( rsp_o			),
		.irq_i		( irq_o			),
		.rst_busy_i	( rst_busy_o	),
		.chk_cnt_o	( chk_cnt		),
		.err_cnt_o	( err_cnt		)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr	= lfsr_step(lfsr);
			v		= {v[30:0], lfsr[0]};	// One step per bit
		end
	endtask

	task automatic make_req(input int mode, output csr_req_t req);
		logic [31:0]	r;
		int unsigned	idx;
		csr_reg_e		sel;
		timer_ctrl_t	c;
		req		= '0;
		req.stb	= 1'b1;
		draw_bits(1, r);
		req.we	= r[0];
		draw_bits(3, r);
		idx		= r % 5;	// Index 4 has no timer
		draw_bits(2, r);
		sel		= csr_reg_e'(r[1:0]);
		req.addr = {IDX_W'(idx), sel};
		case (sel)
			REG_CTRL: begin
				draw_bits(3, r);
				c = timer_ctrl_t'(r[2:0]);
				if (mode == MODE_READBACK)
					c.enable = 1'b0;
				if (mode == MODE_COUNT) begin
					c.enable		= c.enable | c.autoreload;
					c.irq_enable	= 1'b0;
				end
				req.data = DW'(c);
			end
			REG_COMPARE: begin
				draw_bits(4, r);	// Small, so expiry comes often
				req.data = r;
			end
			REG_COUNT: begin
				draw_bits(3, r);
				req.data = r;
			end
			default: begin
				draw_bits(2, r);	// Bit 0 clears pending
				req.data = r;
			end
		endcase
	endtask

	task automatic drive_req(input csr_req_t req);
		@(posedge sys_clk);
		#DRIVE_DLY;
		req_i = req;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_req('0);
	endtask

	// Request on about three cycles in four
	task automatic run_random(input int mode, input int cycles);
		csr_req_t		req;
		logic [31:0]	r;
		for (int c = 0; c < cycles; c++) begin
			draw_bits(2, r);
			if (r[1:0] != 2'b00)
				make_req(mode, req);
			else
				req = '0;
			drive_req(req);
		end
	endtask

	// Bursts of 4 to 11 strobes, gaps of 0 to 3 cycles
	task automatic run_bursts(input int cycles);
		csr_req_t		req;
		logic [31:0]	r;
		int				burst_left;
		int				gap_left;
		burst_left	= 0;
		gap_left	= 0;
		for (int c = 0; c < cycles; c++) begin
			if (burst_left == 0 && gap_left == 0) begin
				draw_bits(3, r);
				burst_left = 4 + int'(r);
				draw_bits(2, r);
				gap_left = int'(r);
			end
			if (burst_left > 0) begin
				make_req(MODE_IRQ, req);
				burst_left--;
			end else begin
				req = '0;
				gap_left--;
			end
			drive_req(req);
		end
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		int chks;
		errs = err_cnt - err_mark;
		chks = chk_cnt - chk_mark;
		$display("Test %0d %s: %0d checks, %0d errors, %s", num, name, chks, errs,
			(errs == 0) ? "ok" : "failed");
		err_mark = err_cnt;
		chk_mark = chk_cnt;
	endtask

	initial begin : stimulus
		csr_req_t req;

		lfsr		= LFSR_SEED;
		req_i		= '0;
		hard_reset	= 1'b1;
		chk_mark	= 0;
		err_mark	= 0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#DRIVE_DLY;
		hard_reset = 1'b0;

		// Hold window traffic, none of it may be answered
		while (rst_busy_o) begin
			make_req(MODE_IRQ, req);
			drive_req(req);
		end
		idle(DRAIN_CYCLES);
		report_test(1, "reset hold");

		run_random(MODE_READBACK, READBACK_CYCLES);
		idle(DRAIN_CYCLES);
		report_test(2, "register readback");

		run_random(MODE_COUNT, COUNT_CYCLES);
		idle(DRAIN_CYCLES);
		report_test(3, "counting and expiry");

		run_random(MODE_IRQ, IRQ_CYCLES);
		idle(DRAIN_CYCLES);
		report_test(4, "interrupts");

		run_bursts(BURST_CYCLES);
		idle(DRAIN_CYCLES);
		report_test(5, "back-to-back traffic");

		$display("Totals: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Stimulus length plus margin
	initial begin : watchdog
		#((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles",
			TOTAL_CYCLES + MARGIN_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
csr_pkg.sv
reset_stretch.sv
wb_csr_bridge.sv
csr_timer.sv
csr_collect.sv
timer_soc_top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the timer CSR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
